/* hw/sound_pkg.sv */
package sound_pkg;

  // channel count and sample format
  localparam int NUM_CHANNELS = 4;
  localparam int SAMPLE_W = 8;

  // 28 MHz / 16 gives the 1.75 MHz sample rate
  localparam int SAMPLE_DIV = 16;

  // i/o port addresses, low byte only
  localparam logic [7:0] PORT_FE = 8'hFE;
  localparam logic [7:0] PORT_COVOX_ALL = 8'hFB;
  localparam logic [7:0] CHANNEL_PORTS [NUM_CHANNELS] = '{8'h0F, 8'h1F, 8'h4F, 8'h5F};

  // bit positions in the #FE register
  localparam int SPEAKER_BIT = 4;
  localparam int TAPE_OUT_BIT = 3;

  // levels added to each side of the mix
  localparam int BEEPER_LEVEL = 64;
  localparam int TAPE_LEVEL = 16;

  // sum width and scaling to the 16-bit output
  localparam int MIX_W = 10;
  localparam int OUT_SHIFT = 6;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // z80 bus as seen at the top level
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic        iorq_n;
    logic        wr_n;
    logic        m1_n;
    logic        dos;
  } z80_io_t;

  // one strobe per channel, all set for #FB
  typedef struct packed {
    logic [NUM_CHANNELS-1:0] strobe;
    sample_t                 data;
  } channel_wr_t;

  typedef struct packed {
    logic speaker;
    logic tape_level;
  } beeper_t;

  // code 3 falls through to mute
  typedef enum logic [1:0] {
    MIX_STEREO = 2'd0,
    MIX_MONO   = 2'd1,
    MIX_MUTE   = 2'd2
  } mix_mode_e;

endpackage

/* hw/sound_bus_frontend.sv */
`timescale 1ns/1ns

module sound_bus_frontend (
  input  logic                    clk_28mhz,
  input  logic                    rst,
  input  sound_pkg::z80_io_t      bus,
  input  logic                    tape_in,
  input  logic                    covox_en,
  output sound_pkg::channel_wr_t  channel_wr,
  output sound_pkg::beeper_t      beeper,
  output logic                    tape_out,
  output logic                    sample_tick
);

  logic                                   io_wr;
  logic                                   io_wr_q;
  logic                                   io_wr_start;
  logic [7:0]                             port_lo;
  logic                                   covox_ok;
  logic [sound_pkg::NUM_CHANNELS-1:0]     covox_hit;
  logic [sound_pkg::NUM_CHANNELS-1:0]     strobe_q;
  sound_pkg::sample_t                     wr_data_q;
  logic [7:0]                             port_fe_q;
  logic                                   tape_meta;
  logic                                   tape_sync;
  logic [$clog2(sound_pkg::SAMPLE_DIV)-1:0] div_cnt;

  // qualified z80 i/o write, opcode fetch excluded
  assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;
  assign io_wr_start = io_wr & ~io_wr_q;

  assign port_lo = bus.addr[7:0];

  // covox ports are hidden while the dos rom is paged in
  assign covox_ok = covox_en & ~bus.dos;

  always_comb begin
    for (int i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin
      covox_hit[i] = covox_ok &
                     ((port_lo == sound_pkg::CHANNEL_PORTS[i]) ||
                      (port_lo == sound_pkg::PORT_COVOX_ALL));
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      io_wr_q <= 1'b0;
    end else begin
      io_wr_q <= io_wr;
    end
  end

  // strobes last one cycle, only on the first cycle of a write
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      strobe_q <= '0;
    end else if (io_wr_start) begin
      strobe_q <= covox_hit;
    end else begin
      strobe_q <= '0;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (io_wr_start) begin
      wr_data_q <= bus.data;
    end
  end

  assign channel_wr = '{strobe: strobe_q, data: wr_data_q};

  // port #FE, loaded regardless of covox_en
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      port_fe_q <= '0;
    end else if (io_wr_start && port_lo == sound_pkg::PORT_FE) begin
      port_fe_q <= bus.data;
    end
  end

  assign tape_out = port_fe_q[sound_pkg::TAPE_OUT_BIT];

  // two-flop sync for the async tape input
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      tape_meta <= 1'b0;
      tape_sync <= 1'b0;
    end else begin
      tape_meta <= tape_in;
      tape_sync <= tape_meta;
    end
  end

  assign beeper = '{speaker: port_fe_q[sound_pkg::SPEAKER_BIT], tape_level: tape_sync};

  // free-running divider, tick on the last count
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      div_cnt     <= '0;
      sample_tick <= 1'b0;
    end else begin
      div_cnt     <= div_cnt + 1'b1;
      sample_tick <= &div_cnt;
    end
  end

endmodule

/* hw/covox_channel.sv */
`timescale 1ns/1ns

module covox_channel (
  input  logic               clk_28mhz,
  input  logic               rst,
  input  logic               wr_strobe,
  input  sound_pkg::sample_t wr_data,
  input  logic               sample_tick,
  output sound_pkg::sample_t sample
);

  sound_pkg::sample_t pending;
  logic               pending_vld;

  // latest write wins until the tick takes it
  always_ff @(posedge clk_28mhz) begin
    if (wr_strobe) begin
      pending <= wr_data;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      pending_vld <= 1'b0;
    end else if (wr_strobe) begin
      pending_vld <= 1'b1;
    end else if (sample_tick) begin
      pending_vld <= 1'b0;
    end
  end

  // commit on the shared tick so a #FB write lands in all channels together
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      sample <= '0;
    end else if (sample_tick && pending_vld) begin
      sample <= pending;
    end
  end

endmodule

/* hw/audio_mixer.sv */
`timescale 1ns/1ns

module audio_mixer (
  input  logic                  clk_28mhz,
  input  logic                  rst,
  input  sound_pkg::sample_t    samples [sound_pkg::NUM_CHANNELS],
  input  sound_pkg::beeper_t    beeper,
  input  sound_pkg::mix_mode_e  mode,
  input  logic                  sample_tick,
  output logic [15:0]           audio_out_l,
  output logic [15:0]           audio_out_r
);

  logic [sound_pkg::MIX_W-1:0] beep_add;
  logic [sound_pkg::MIX_W-1:0] tape_add;
  logic [sound_pkg::MIX_W-1:0] sum_l;
  logic [sound_pkg::MIX_W-1:0] sum_r;
  logic [sound_pkg::MIX_W:0]   sum_total;
  logic [sound_pkg::MIX_W-1:0] sum_mono;
  logic [15:0]                 stereo_l;
  logic [15:0]                 stereo_r;
  logic [15:0]                 mono;
  logic [15:0]                 next_l;
  logic [15:0]                 next_r;

  // beeper and tape go to both sides
  assign beep_add = beeper.speaker ?
                    (sound_pkg::MIX_W)'(sound_pkg::BEEPER_LEVEL) : '0;
  assign tape_add = beeper.tape_level ?
                    (sound_pkg::MIX_W)'(sound_pkg::TAPE_LEVEL) : '0;

  // lower half of the channels goes left, upper half right
  always_comb begin
    sum_l = beep_add + tape_add;
    sum_r = beep_add + tape_add;
    for (int i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin
      if (i < sound_pkg::NUM_CHANNELS / 2) begin
        sum_l = sum_l + (sound_pkg::MIX_W)'(samples[i]);
      end else begin
        sum_r = sum_r + (sound_pkg::MIX_W)'(samples[i]);
      end
    end
  end

  // mono is the floor of the average of both sides
  assign sum_total = {1'b0, sum_l} + {1'b0, sum_r};
  assign sum_mono  = sum_total[sound_pkg::MIX_W:1];

  assign stereo_l = 16'(sum_l) << sound_pkg::OUT_SHIFT;
  assign stereo_r = 16'(sum_r) << sound_pkg::OUT_SHIFT;
  assign mono     = 16'(sum_mono) << sound_pkg::OUT_SHIFT;

  always_comb begin
    case (mode)
      sound_pkg::MIX_STEREO: begin
        next_l = stereo_l;
        next_r = stereo_r;
      end
      sound_pkg::MIX_MONO: begin
        next_l = mono;
        next_r = mono;
      end
      // mute and the spare code
      default: begin
        next_l = '0;
        next_r = '0;
      end
    endcase
  end

  // outputs move only at the sample rate
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else if (sample_tick) begin
      audio_out_l <= next_l;
      audio_out_r <= next_r;
    end
  end

endmodule

/* hw/sound_top.sv */
`timescale 1ns/1ns

module sound_top (
  input  logic                  clk_28mhz,
  input  logic                  rst,
  input  sound_pkg::z80_io_t    bus,
  input  logic                  tape_in,
  input  logic                  covox_en,
  input  sound_pkg::mix_mode_e  psg_mix,
  output logic [15:0]           audio_out_l,
  output logic [15:0]           audio_out_r,
  output logic                  tape_out
);

  sound_pkg::channel_wr_t channel_wr;
  sound_pkg::beeper_t     beeper;
  logic                   sample_tick;
  sound_pkg::sample_t     ch_samples [sound_pkg::NUM_CHANNELS];

  sound_bus_frontend u_frontend (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .bus         (bus),
    .tape_in     (tape_in),
    .covox_en    (covox_en),
    .channel_wr  (channel_wr),
    .beeper      (beeper),
    .tape_out    (tape_out),
    .sample_tick (sample_tick)
  );

  // one dac per covox port, all sharing the write data
  for (genvar i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin : g_channel
    covox_channel u_channel (
      .clk_28mhz   (clk_28mhz),
      .rst         (rst),
      .wr_strobe   (channel_wr.strobe[i]),
      .wr_data     (channel_wr.data),
      .sample_tick (sample_tick),
      .sample      (ch_samples[i])
    );
  end

  audio_mixer u_mixer (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .samples     (ch_samples),
    .beeper      (beeper),
    .mode        (psg_mix),
    .sample_tick (sample_tick),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

endmodule

/* testbench/tb_sound.sv */
`timescale 1ns/1ns

module tb_sound;

  localparam int NUM_TESTS = 6;
  localparam int SETTLE_CYCLES = 40;
  localparam logic [15:0] LFSR_SEED = 16'd33402;

  logic                     clk_28mhz;
  logic                     rst;
  sound_pkg::z80_io_t       bus;
  logic                     tape_in;
  logic                     covox_en;
  sound_pkg::mix_mode_e     psg_mix;
  logic [15:0]              audio_out_l;
  logic [15:0]              audio_out_r;
  logic                     tape_out;

  // reference state of what the DUT should hold
  int                       model_ch [sound_pkg::NUM_CHANNELS];
  bit                       model_spk;
  bit                       model_tape;
  int                       model_mode;

  logic [15:0]              lfsr_state;
  int                       checks;
  int                       errors;
  int                       test_errors_start;
  int                       tests_run;

  sound_top dut_i (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .bus         (bus),
    .tape_in     (tape_in),
    .covox_en    (covox_en),
    .psg_mix     (psg_mix),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r),
    .tape_out    (tape_out)
  );

  initial begin
    clk_28mhz = 1'b0;
    forever #10 clk_28mhz = ~clk_28mhz;
  end

  // taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return b;
  endfunction

  // sum for one side, first_ch and the channel after it
  function automatic int side_sum(input int first_ch);
    int s;
    s = model_ch[first_ch] + model_ch[first_ch + 1];
    if (model_spk) begin
      s = s + sound_pkg::BEEPER_LEVEL;
    end
    if (model_tape) begin
      s = s + sound_pkg::TAPE_LEVEL;
    end
    return s;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%04h expected 0x%04h", name, got, exp);
      errors++;
    end
  endtask

  // sample on the falling edge, well away from register updates
  task automatic check_audio();
    int          sl;
    int          sr;
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    sl = side_sum(0);
    sr = side_sum(2);
    case (model_mode)
      0: begin
        exp_l = 16'(sl << sound_pkg::OUT_SHIFT);
        exp_r = 16'(sr << sound_pkg::OUT_SHIFT);
      end
      1: begin
        exp_l = 16'(((sl + sr) / 2) << sound_pkg::OUT_SHIFT);
        exp_r = exp_l;
      end
      default: begin
        exp_l = '0;
        exp_r = '0;
      end
    endcase
    @(negedge clk_28mhz);
    check_value("audio_out_l", audio_out_l, exp_l);
    check_value("audio_out_r", audio_out_r, exp_r);
  endtask

  task automatic settle();
    repeat (SETTLE_CYCLES) @(posedge clk_28mhz);
  endtask

  // qualified write held for 4 cycles, then one idle cycle
  task automatic io_write(input logic [7:0] port, input logic [7:0] data,
                          input logic m1_n, input logic dos);
    @(posedge clk_28mhz);
    bus.addr   <= {8'hA5, port};
    bus.data   <= data;
    bus.iorq_n <= 1'b0;
    bus.wr_n   <= 1'b0;
    bus.m1_n   <= m1_n;
    bus.dos    <= dos;
    repeat (4) @(posedge clk_28mhz);
    bus.iorq_n <= 1'b1;
    bus.wr_n   <= 1'b1;
    bus.m1_n   <= 1'b1;
    bus.dos    <= 1'b0;
    @(posedge clk_28mhz);
  endtask

  task automatic set_mode(input sound_pkg::mix_mode_e mode, input int code);
    @(posedge clk_28mhz);
    psg_mix <= mode;
    model_mode = code;
  endtask

  task automatic start_test();
    test_errors_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %s: %0d errors", name, errors - test_errors_start);
  endtask

  task automatic test_reset();
    start_test();
    @(negedge clk_28mhz);
    check_value("audio_out_l", audio_out_l, 16'h0000);
    check_value("audio_out_r", audio_out_r, 16'h0000);
    check_value("tape_out", {15'd0, tape_out}, 16'h0000);
    finish_test("reset");
  endtask

  task automatic test_single_channels();
    logic [7:0] data;
    start_test();
    for (int i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin
      data = random_byte();
      io_write(sound_pkg::CHANNEL_PORTS[i], data, 1'b1, 1'b0);
      model_ch[i] = int'(data);
      settle();
      check_audio();
    end
    finish_test("single_channels");
  endtask

  task automatic test_all_channels();
    logic [7:0] data;
    start_test();
    data = random_byte();
    io_write(sound_pkg::PORT_COVOX_ALL, data, 1'b1, 1'b0);
    for (int i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin
      model_ch[i] = int'(data);
    end
    settle();
    check_audio();
    finish_test("all_channels");
  endtask

  task automatic test_port_fe();
    start_test();
    // tape out only
    io_write(sound_pkg::PORT_FE, 8'h08, 1'b1, 1'b0);
    settle();
    @(negedge clk_28mhz);
    check_value("tape_out", {15'd0, tape_out}, 16'h0001);
    check_audio();
    // speaker on as well
    io_write(sound_pkg::PORT_FE, 8'h18, 1'b1, 1'b0);
    model_spk = 1'b1;
    settle();
    check_audio();
    @(posedge clk_28mhz);
    tape_in <= 1'b1;
    model_tape = 1'b1;
    settle();
    check_audio();
    // back to quiet
    io_write(sound_pkg::PORT_FE, 8'h00, 1'b1, 1'b0);
    tape_in <= 1'b0;
    model_spk = 1'b0;
    model_tape = 1'b0;
    settle();
    @(negedge clk_28mhz);
    check_value("tape_out", {15'd0, tape_out}, 16'h0000);
    check_audio();
    finish_test("port_fe");
  endtask

  task automatic test_ignored_writes();
    start_test();
    @(posedge clk_28mhz);
    covox_en <= 1'b0;
    io_write(sound_pkg::CHANNEL_PORTS[0], random_byte(), 1'b1, 1'b0);
    settle();
    check_audio();
    @(posedge clk_28mhz);
    covox_en <= 1'b1;
    io_write(sound_pkg::CHANNEL_PORTS[1], random_byte(), 1'b1, 1'b1);
    settle();
    check_audio();
    // opcode fetch cycle is not an i/o write
    io_write(sound_pkg::PORT_COVOX_ALL, random_byte(), 1'b0, 1'b0);
    settle();
    check_audio();
    finish_test("ignored_writes");
  endtask

  task automatic test_modes();
    start_test();
    // unequal sides and an odd total for mono
    io_write(sound_pkg::CHANNEL_PORTS[0], 8'h31, 1'b1, 1'b0);
    model_ch[0] = 'h31;
    io_write(sound_pkg::CHANNEL_PORTS[3], 8'hC4, 1'b1, 1'b0);
    model_ch[3] = 'hC4;
    settle();
    check_audio();
    set_mode(sound_pkg::MIX_MONO, 1);
    settle();
    check_audio();
    set_mode(sound_pkg::MIX_MUTE, 2);
    settle();
    check_audio();
    set_mode(sound_pkg::mix_mode_e'(2'd3), 3);
    settle();
    check_audio();
    set_mode(sound_pkg::MIX_STEREO, 0);
    settle();
    check_audio();
    finish_test("modes");
  endtask

  // bounds the run by the total length of the tests
  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk_28mhz);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    bus = '{addr: 16'h0000, data: 8'h00, iorq_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1, dos: 1'b0};
    tape_in = 1'b0;
    covox_en = 1'b1;
    psg_mix = sound_pkg::MIX_STEREO;
    lfsr_state = LFSR_SEED;
    checks = 0;
    errors = 0;
    tests_run = 0;
    test_errors_start = 0;
    model_spk = 1'b0;
    model_tape = 1'b0;
    model_mode = 0;
    for (int i = 0; i < sound_pkg::NUM_CHANNELS; i++) begin
      model_ch[i] = 0;
    end
    repeat (3) @(posedge clk_28mhz);
    rst <= 1'b0;
    @(posedge clk_28mhz);

    test_reset();
    test_single_channels();
    test_all_channels();
    test_port_fe();
    test_ignored_writes();
    test_modes();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
hw/sound_pkg.sv
hw/sound_bus_frontend.sv
hw/covox_channel.sv
hw/audio_mixer.sv
hw/sound_top.sv
testbench/tb_sound.sv

/* Makefile */
# Verilator flow for the sound subsystem

VERILATOR  ?= verilator
FILELIST   ?= src.f
TOP        ?= tb_sound
RTL_TOP    ?= sound_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --assert -Wno-fatal
JOBS       ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
